// ==== lsu_stbuf.f ====
source/lsu_stbuf_pkg.sv
source/stbuf_write_if.sv
source/stbuf_head_if.sv
source/stbuf_alloc.sv
source/stbuf_array.sv
source/stbuf_fwd.sv
source/stbuf_drain.sv
source/lsu_stbuf.sv
test/lsu_stbuf_checker.sv
test/lsu_stbuf_tb.sv

// ==== test/lsu_stbuf_tb.sv ====
// ----------------------------------------
// store buffer testbench
// step table of stores and load checks,
// random-delay memory responder and an
// in-order drain scoreboard
// ----------------------------------------
`default_nettype none

module lsu_stbuf_tb
   import lsu_stbuf_pkg::*;
();

   localparam int PERIOD = 20;

   typedef enum logic [2:0] {
      OP_STORE, OP_LOAD, OP_IDLE, OP_HOLD, OP_RELEASE, OP_DRAIN, OP_FULL
   } op_t;

   typedef struct {
      op_t             kind;
      logic [15:0]     addr;
      access_size_t    size;
      logic [31:0]     data;     // store data, or expected load data
      logic            kill;
      logic [3:0]      byteen;   // expected load byte enables
   } step_t;

   typedef struct {
      logic [15:0] addr;
      logic [3:0]  byteen;
      logic [31:0] data;
   } drain_t;

   logic clk, rst;
   logic store_valid, store_kill, load_valid, mem_ack, mem_req;
   logic [ADDR_BITS-1:0]  store_addr, load_addr, mem_addr;
   access_size_t          store_size;
   logic [DATA_WIDTH-1:0] store_data, fwd_data, mem_data;
   logic [BYTE_WIDTH-1:0] fwd_byteen, mem_byteen;
   logic                  stbuf_full, stbuf_empty;

   step_t  steps [$];
   drain_t sb [$];          // expected drains in issue order
   logic   table_ready = 1'b0;
   logic   ack_hold    = 1'b0;
   logic   kill_hist [2];   // kill lands two cycles after its store
   integer seed;

   lsu_stbuf lsu_stbuf_i (.*);

   initial begin
      clk = 1'b0;
      forever #(PERIOD/2) clk = ~clk;
   end

   // ----------------------------------------
   // helpers
   // ----------------------------------------
   task automatic abort_run();
      $display("Test FAILED");
      $fatal(1);
   endtask

   task automatic check_value(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
         abort_run();
      end
   endtask

   // size mask moved to the byte offset and cut to four bits
   function automatic logic [3:0] byte_mask(input access_size_t size, input logic [1:0] ofs);
      logic [3:0] mask;
      mask = (size == size_word) ? 4'hf : (size == size_half) ? 4'h3 : 4'h1;
      return mask << ofs;
   endfunction

   function automatic step_t make_step(input op_t kind, input logic [15:0] addr,
                                       input access_size_t size, input logic [31:0] data,
                                       input logic kill, input logic [3:0] byteen);
      step_t s;
      s.kind   = kind;
      s.addr   = addr;
      s.size   = size;
      s.data   = data;
      s.kill   = kill;
      s.byteen = byteen;
      return s;
   endfunction

   task automatic step_clock();
      @(negedge clk);
      store_kill   = kill_hist[1];
      kill_hist[1] = kill_hist[0];
      kill_hist[0] = 1'b0;
   endtask

   task automatic build_table();
      // in-order drain of all sizes and offsets
      steps.push_back(make_step(OP_STORE, 16'h0100, size_word, 32'h11223344, 1'b0, 4'h0));
      steps.push_back(make_step(OP_STORE, 16'h0104, size_half, 32'h00005566, 1'b0, 4'h0));
      steps.push_back(make_step(OP_STORE, 16'h010a, size_half, 32'h77880000, 1'b0, 4'h0));
      steps.push_back(make_step(OP_STORE, 16'h0113, size_byte, 32'hab000000, 1'b0, 4'h0));
      steps.push_back(make_step(OP_DRAIN, 16'h0000, size_byte, 32'h0, 1'b0, 4'h0));
      // killed stores between committed ones
      steps.push_back(make_step(OP_STORE, 16'h0200, size_word, 32'h0a0b0c0d, 1'b0, 4'h0));
      steps.push_back(make_step(OP_STORE, 16'h0204, size_word, 32'hdeadbeef, 1'b1, 4'h0));
      steps.push_back(make_step(OP_STORE, 16'h0209, size_byte, 32'h00003300, 1'b1, 4'h0));
      steps.push_back(make_step(OP_STORE, 16'h020c, size_word, 32'h13579bdf, 1'b0, 4'h0));
      steps.push_back(make_step(OP_DRAIN, 16'h0000, size_byte, 32'h0, 1'b0, 4'h0));
      // forwarding with a killed byte while acks are held
      steps.push_back(make_step(OP_HOLD,  16'h0000, size_byte, 32'h0, 1'b0, 4'h0));
      steps.push_back(make_step(OP_STORE, 16'h0300, size_word, 32'ha0a1a2a3, 1'b0, 4'h0));
      steps.push_back(make_step(OP_STORE, 16'h0302, size_half, 32'hb1b00000, 1'b0, 4'h0));
      steps.push_back(make_step(OP_STORE, 16'h0301, size_byte, 32'h0000c100, 1'b1, 4'h0));
      steps.push_back(make_step(OP_STORE, 16'h0303, size_byte, 32'hd1000000, 1'b0, 4'h0));
      steps.push_back(make_step(OP_IDLE,  16'h0000, size_byte, 32'h0, 1'b0, 4'h0));
      steps.push_back(make_step(OP_IDLE,  16'h0000, size_byte, 32'h0, 1'b0, 4'h0));
      steps.push_back(make_step(OP_LOAD,  16'h0300, size_word, 32'hd1b0a2a3, 1'b0, 4'hf));
      steps.push_back(make_step(OP_LOAD,  16'h0302, size_word, 32'hd1b0a2a3, 1'b0, 4'hf));
      steps.push_back(make_step(OP_LOAD,  16'h0304, size_word, 32'h00000000, 1'b0, 4'h0));
      steps.push_back(make_step(OP_FULL,  16'h0000, size_byte, 32'h0, 1'b0, 4'h0));
      steps.push_back(make_step(OP_RELEASE, 16'h0000, size_byte, 32'h0, 1'b0, 4'h0));
      steps.push_back(make_step(OP_DRAIN, 16'h0000, size_byte, 32'h0, 1'b0, 4'h0));
      // fill under back-pressure where the newest store wins per byte
      steps.push_back(make_step(OP_HOLD,  16'h0000, size_byte, 32'h0, 1'b0, 4'h0));
      steps.push_back(make_step(OP_STORE, 16'h0400, size_word, 32'h01020304, 1'b0, 4'h0));
      steps.push_back(make_step(OP_STORE, 16'h0400, size_byte, 32'h000000ff, 1'b0, 4'h0));
      steps.push_back(make_step(OP_STORE, 16'h0402, size_half, 32'h55660000, 1'b0, 4'h0));
      steps.push_back(make_step(OP_STORE, 16'h0500, size_word, 32'hcafef00d, 1'b0, 4'h0));
      steps.push_back(make_step(OP_IDLE,  16'h0000, size_byte, 32'h0, 1'b0, 4'h0));
      steps.push_back(make_step(OP_FULL,  16'h0000, size_byte, 32'h0, 1'b0, 4'h0));
      steps.push_back(make_step(OP_LOAD,  16'h0400, size_word, 32'h556603ff, 1'b0, 4'hf));
      steps.push_back(make_step(OP_LOAD,  16'h0500, size_word, 32'hcafef00d, 1'b0, 4'hf));
      steps.push_back(make_step(OP_RELEASE, 16'h0000, size_byte, 32'h0, 1'b0, 4'h0));
      steps.push_back(make_step(OP_DRAIN, 16'h0000, size_byte, 32'h0, 1'b0, 4'h0));
   endtask

   // ----------------------------------------
   // memory responder and drain compare
   // ----------------------------------------
   initial begin : mem_responder
      int unsigned delay;
      drain_t      exp_drain;
      seed    = 32'h9ff29971;
      mem_ack = 1'b0;
      forever begin
         @(negedge clk);
         if (mem_req && !mem_ack) begin
            delay = $unsigned($random(seed)) % 6;
            repeat (delay) @(negedge clk);
            while (ack_hold) @(negedge clk);   // back-pressure
            if (sb.size() == 0) begin
               $display("memory write at time %0t with no committed store pending", $time);
               abort_run();
            end else begin
               exp_drain = sb.pop_front();
               check_value("mem_addr", 32'(mem_addr), 32'(exp_drain.addr));
               check_value("mem_byteen", 32'(mem_byteen), 32'(exp_drain.byteen));
               check_value("mem_data", mem_data, exp_drain.data);
               mem_ack = 1'b1;
               while (mem_req) @(negedge clk);
               mem_ack = 1'b0;
            end
         end
      end
   end

   initial begin : watchdog
      wait (table_ready);
      #(steps.size() * 20 * PERIOD);
      $display("timeout, the step table did not complete in time");
      abort_run();
   end

   // failed assertions in the bound checkers
   initial begin : assert_monitor
      wait (lsu_stbuf_i.array_i.array_chk_i.fail_cnt != 0 ||
            lsu_stbuf_i.drain_i.drain_chk_i.fail_cnt != 0);
      $display("a bound assertion failed at time %0t", $time);
      abort_run();
   end

   // ----------------------------------------
   // main sequence
   // ----------------------------------------
   initial begin : main_seq
      logic        load_pend;
      logic [3:0]  pend_byteen;
      logic [31:0] pend_data;
      rst = 1'b1;
      store_valid = 1'b0;
      store_addr  = '0;
      store_size  = size_byte;
      store_data  = '0;
      store_kill  = 1'b0;
      load_valid  = 1'b0;
      load_addr   = '0;
      kill_hist[0] = 1'b0;
      kill_hist[1] = 1'b0;
      load_pend   = 1'b0;
      pend_byteen = '0;
      pend_data   = '0;
      build_table();
      table_ready = 1'b1;

      repeat (3) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      check_value("mem_req", 32'(mem_req), 32'd0);       // reset state
      check_value("stbuf_full", 32'(stbuf_full), 32'd0);
      check_value("stbuf_empty", 32'(stbuf_empty), 32'd1);
      check_value("fwd_byteen", 32'(fwd_byteen), 32'd0);

      foreach (steps[i]) begin
         step_clock();
         if (load_pend) begin   // registered result of the previous load
            check_value("fwd_byteen", 32'(fwd_byteen), 32'(pend_byteen));
            check_value("fwd_data", fwd_data, pend_data);
            load_pend = 1'b0;
         end
         store_valid = 1'b0;
         load_valid  = 1'b0;
         case (steps[i].kind)
            OP_STORE: begin
               store_valid  = 1'b1;
               store_addr   = steps[i].addr;
               store_size   = steps[i].size;
               store_data   = steps[i].data;
               kill_hist[0] = steps[i].kill;
               if (!steps[i].kill) begin
                  sb.push_back('{steps[i].addr,
                                 byte_mask(steps[i].size, steps[i].addr[1:0]),
                                 steps[i].data});
               end
            end
            OP_LOAD: begin
               load_valid  = 1'b1;
               load_addr   = steps[i].addr;
               load_pend   = 1'b1;
               pend_byteen = steps[i].byteen;
               pend_data   = steps[i].data;
            end
            OP_HOLD:    ack_hold = 1'b1;
            OP_RELEASE: ack_hold = 1'b0;
            OP_FULL: begin
               check_value("stbuf_full", 32'(stbuf_full), 32'd1);
               check_value("stbuf_empty", 32'(stbuf_empty), 32'd0);
            end
            OP_DRAIN: begin
               while (!(stbuf_empty && sb.size() == 0 && !mem_ack)) step_clock();
            end
            default: ;
         endcase
      end

      step_clock();
      $display("Test OK");
      $finish;
   end

endmodule

`default_nettype wire

// ==== test/lsu_stbuf_checker.sv ====
// ----------------------------------------
// store buffer assertions
// resolution bits, store while full and
// the req/ack memory handshake
// ----------------------------------------
`default_nettype none

module lsu_stbuf_checker
   import lsu_stbuf_pkg::*;
(
   input logic                      clk,
   input logic                      rst,
   input logic                      res_valid,
   input logic [STBUF_PTR_BITS-1:0] res_idx,
   input logic [STBUF_DEPTH-1:0]    ent_drain,
   input logic [STBUF_DEPTH-1:0]    ent_flush,
   input logic                      wr_en,
   input logic                      stbuf_full,
   input logic                      mem_req,
   input logic                      mem_ack,
   input logic [ADDR_BITS-1:0]      mem_addr,
   input logic [BYTE_WIDTH-1:0]     mem_data_en_unused_guard_free = '0,
   input logic [BYTE_WIDTH-1:0]     mem_byteen,
   input logic [DATA_WIDTH-1:0]     mem_data
);

   int unsigned fail_cnt = 0;   // failed assertions so far

   // each entry gets one resolution and is never both committed and killed
   a_resolve_once: assert property (@(posedge clk) disable iff (rst)
      res_valid |-> !ent_drain[res_idx] && !ent_flush[res_idx])
      else begin
         fail_cnt++;
         $error("entry resolved while already committed or killed");
      end

   a_no_store_full: assert property (@(posedge clk) disable iff (rst)
      wr_en |-> !stbuf_full)
      else begin
         fail_cnt++;
         $error("store written while the buffer is full");
      end

   // req only rises once ack was low in the cycle before
   a_req_rise: assert property (@(posedge clk) disable iff (rst)
      $rose(mem_req) |-> !$past(mem_ack))
      else begin
         fail_cnt++;
         $error("mem_req rose while mem_ack was high");
      end

   a_bus_stable: assert property (@(posedge clk) disable iff (rst)
      mem_req && $past(mem_req) |->
         $stable(mem_addr) && $stable(mem_byteen) && $stable(mem_data))
      else begin
         fail_cnt++;
         $error("memory bus changed while mem_req was high");
      end

endmodule

// array instance with the handshake inputs tied off
bind stbuf_array lsu_stbuf_checker array_chk_i (
   .clk        (clk),
   .rst        (rst),
   .res_valid  (res_valid),
   .res_idx    (res_idx),
   .ent_drain  (ent_drain),
   .ent_flush  (ent_flush),
   .wr_en      (wr.wr_en),
   .stbuf_full (stbuf_full),
   .mem_req    (1'b0),
   .mem_ack    (1'b0),
   .mem_addr   ('0),
   .mem_byteen ('0),
   .mem_data   ('0)
);

// drain instance with the entry inputs tied off
bind stbuf_drain lsu_stbuf_checker drain_chk_i (
   .clk        (clk),
   .rst        (rst),
   .res_valid  (1'b0),
   .res_idx    ('0),
   .ent_drain  ('0),
   .ent_flush  ('0),
   .wr_en      (1'b0),
   .stbuf_full (1'b0),
   .mem_req    (mem_req),
   .mem_ack    (mem_ack),
   .mem_addr   (mem_addr),
   .mem_byteen (mem_byteen),
   .mem_data   (mem_data)
);

`default_nettype wire

// ==== source/lsu_stbuf.sv ====
// ----------------------------------------
// lsu store buffer
// four entries, dc3 write, dc5 commit or
// kill, in order drain over req/ack and
// registered load forwarding
// ----------------------------------------
`default_nettype none

module lsu_stbuf
   import lsu_stbuf_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst,

   // store from dc3, kill at dc5
   input  logic                   store_valid,
   input  logic [ADDR_BITS-1:0]   store_addr,
   input  access_size_t           store_size,
   input  logic [DATA_WIDTH-1:0]  store_data,
   input  logic                   store_kill,

   // load forwarding
   input  logic                   load_valid,
   input  logic [ADDR_BITS-1:0]   load_addr,
   output logic [BYTE_WIDTH-1:0]  fwd_byteen,
   output logic [DATA_WIDTH-1:0]  fwd_data,

   // memory write handshake
   output logic                   mem_req,
   input  logic                   mem_ack,
   output logic [ADDR_BITS-1:0]   mem_addr,
   output logic [BYTE_WIDTH-1:0]  mem_byteen,
   output logic [DATA_WIDTH-1:0]  mem_data,

   output logic                   stbuf_full,
   output logic                   stbuf_empty
);

   logic                                    res_valid;
   logic [STBUF_PTR_BITS-1:0]               res_idx;
   logic                                    res_commit;
   logic [STBUF_DEPTH-1:0]                  ent_valid;
   logic [STBUF_DEPTH-1:0]                  ent_flush;
   logic [STBUF_DEPTH-1:0][WORD_BITS-1:0]   ent_word;
   logic [STBUF_DEPTH-1:0][BYTE_WIDTH-1:0]  ent_byteen;
   logic [STBUF_DEPTH-1:0][DATA_WIDTH-1:0]  ent_data;

   stbuf_write_if wr_if ();
   stbuf_head_if  head_if ();

   stbuf_alloc alloc_i (
      .clk         (clk),
      .rst         (rst),
      .store_valid (store_valid),
      .store_addr  (store_addr),
      .store_size  (store_size),
      .store_data  (store_data),
      .store_kill  (store_kill),
      .wr          (wr_if),
      .res_valid   (res_valid),
      .res_idx     (res_idx),
      .res_commit  (res_commit)
   );

   stbuf_array array_i (
      .clk         (clk),
      .rst         (rst),
      .wr          (wr_if),
      .res_valid   (res_valid),
      .res_idx     (res_idx),
      .res_commit  (res_commit),
      .head        (head_if),
      .ent_valid   (ent_valid),
      .ent_flush   (ent_flush),
      .ent_word    (ent_word),
      .ent_byteen  (ent_byteen),
      .ent_data    (ent_data),
      .stbuf_full  (stbuf_full),
      .stbuf_empty (stbuf_empty)
   );

   stbuf_fwd fwd_i (
      .clk         (clk),
      .rst         (rst),
      .load_valid  (load_valid),
      .load_addr   (load_addr),
      .ent_valid   (ent_valid),
      .ent_flush   (ent_flush),
      .ent_word    (ent_word),
      .ent_byteen  (ent_byteen),
      .ent_data    (ent_data),
      .wr_idx      (wr_if.wr_idx),   // age reference
      .fwd_byteen  (fwd_byteen),
      .fwd_data    (fwd_data)
   );

   stbuf_drain drain_i (
      .clk         (clk),
      .rst         (rst),
      .head        (head_if),
      .mem_req     (mem_req),
      .mem_ack     (mem_ack),
      .mem_addr    (mem_addr),
      .mem_byteen  (mem_byteen),
      .mem_data    (mem_data)
   );

endmodule

`default_nettype wire

// ==== source/stbuf_drain.sv ====
// ----------------------------------------
// store buffer drain engine
// read pointer, silent pop of killed
// heads, four-phase req/ack memory write
// ----------------------------------------
`default_nettype none

module stbuf_drain
   import lsu_stbuf_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst,

   stbuf_head_if.drain            head,

   output logic                   mem_req,
   input  logic                   mem_ack,
   output logic [ADDR_BITS-1:0]   mem_addr,
   output logic [BYTE_WIDTH-1:0]  mem_byteen,
   output logic [DATA_WIDTH-1:0]  mem_data
);

   logic [1:0]                state;
   logic [STBUF_PTR_BITS-1:0] rd_ptr;
   logic                      flush_pop;
   logic                      ack_pop;
   logic                      start_req;
   stbuf_addr_u               hold_addr;
   logic [BYTE_WIDTH-1:0]     hold_byteen;
   logic [DATA_WIDTH-1:0]     hold_data;

   // ----------------------------------------
   // head decisions, only from idle
   // ----------------------------------------
   assign flush_pop = (state == DRAIN_IDLE) & head.head_valid & head.head_flush;
   assign start_req = (state == DRAIN_IDLE) & head.head_valid & head.head_drain;
   assign ack_pop   = (state == DRAIN_REQ) & mem_ack;   // entry done on ack

   assign head.pop    = flush_pop | ack_pop;
   assign head.rd_idx = rd_ptr;

   always_ff @(posedge clk) begin
      if (rst) begin
         state  <= DRAIN_IDLE;
         rd_ptr <= '0;
      end else begin
         if (flush_pop || ack_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case (state)
            DRAIN_IDLE: begin
               if (start_req) begin
                  state <= DRAIN_REQ;
               end
            end
            DRAIN_REQ: begin
               if (mem_ack) begin
                  state <= DRAIN_ACK_LOW;   // req drops next cycle
               end
            end
            DRAIN_ACK_LOW: begin
               // no new request until memory lets go of ack
               if (!mem_ack) begin
                  state <= DRAIN_IDLE;
               end
            end
            default: state <= DRAIN_IDLE;
         endcase
      end
   end

   // held copy keeps the bus stable while req is up
   always_ff @(posedge clk) begin
      if (start_req) begin
         hold_addr   <= head.head_addr;
         hold_byteen <= head.head_byteen;
         hold_data   <= head.head_data;
      end
   end

   assign mem_req    = (state == DRAIN_REQ);
   assign mem_addr   = hold_addr.flat;
   assign mem_byteen = hold_byteen;
   assign mem_data   = hold_data;

endmodule

`default_nettype wire

// ==== source/stbuf_fwd.sv ====
// ----------------------------------------
// store buffer load forwarding
// word compare against all live entries,
// newest store wins each byte, one
// registered stage
// ----------------------------------------
`default_nettype none

module stbuf_fwd
   import lsu_stbuf_pkg::*;
(
   input  logic                                     clk,
   input  logic                                     rst,

   input  logic                                     load_valid,
   input  logic [ADDR_BITS-1:0]                     load_addr,

   input  logic [STBUF_DEPTH-1:0]                   ent_valid,
   input  logic [STBUF_DEPTH-1:0]                   ent_flush,
   input  logic [STBUF_DEPTH-1:0][WORD_BITS-1:0]    ent_word,
   input  logic [STBUF_DEPTH-1:0][BYTE_WIDTH-1:0]   ent_byteen,
   input  logic [STBUF_DEPTH-1:0][DATA_WIDTH-1:0]   ent_data,
   input  logic [STBUF_PTR_BITS-1:0]                wr_idx,

   output logic [BYTE_WIDTH-1:0]                    fwd_byteen,
   output logic [DATA_WIDTH-1:0]                    fwd_data
);

   stbuf_addr_u            ld_addr;
   logic [STBUF_DEPTH-1:0] ld_match;
   logic [BYTE_WIDTH-1:0]  byteen_nxt;
   logic [DATA_WIDTH-1:0]  data_nxt;

   assign ld_addr = load_addr;

   // killed entries never forward, unresolved ones do
   always_comb begin
      for (int i = 0; i < STBUF_DEPTH; i++) begin
         ld_match[i] = ent_valid[i] & ~ent_flush[i] & (ent_word[i] == ld_addr.f.word);
      end
   end

   // ----------------------------------------
   // age ordered merge
   // ----------------------------------------
   always_comb begin
      logic [STBUF_PTR_BITS-1:0] idx;
      byteen_nxt = '0;
      data_nxt   = '0;
      // oldest slot sits at the write pointer, walk forward to the newest
      for (int k = 0; k < STBUF_DEPTH; k++) begin
         idx = wr_idx + STBUF_PTR_BITS'(k);
         for (int b = 0; b < BYTE_WIDTH; b++) begin
            if (ld_match[idx] && ent_byteen[idx][b]) begin
               byteen_nxt[b]     = 1'b1;
               data_nxt[8*b +: 8] = ent_data[idx][8*b +: 8];   // later entry overwrites
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         fwd_byteen <= '0;
         fwd_data   <= '0;
      end else if (load_valid) begin
         fwd_byteen <= byteen_nxt;
         fwd_data   <= data_nxt;
      end else begin
         fwd_byteen <= '0;   // no load, nothing forwarded
         fwd_data   <= '0;
      end
   end

endmodule

`default_nettype wire

// ==== source/stbuf_array.sv ====
// ----------------------------------------
// store buffer entry array
// per entry valid, drain and flush bits,
// address, byte enables and data; head
// mux at the read pointer and occupancy
// ----------------------------------------
`default_nettype none

module stbuf_array
   import lsu_stbuf_pkg::*;
(
   input  logic                                     clk,
   input  logic                                     rst,

   stbuf_write_if.array                             wr,

   input  logic                                     res_valid,
   input  logic [STBUF_PTR_BITS-1:0]                res_idx,
   input  logic                                     res_commit,

   stbuf_head_if.array                              head,

   output logic [STBUF_DEPTH-1:0]                   ent_valid,
   output logic [STBUF_DEPTH-1:0]                   ent_flush,
   output logic [STBUF_DEPTH-1:0][WORD_BITS-1:0]    ent_word,
   output logic [STBUF_DEPTH-1:0][BYTE_WIDTH-1:0]   ent_byteen,
   output logic [STBUF_DEPTH-1:0][DATA_WIDTH-1:0]   ent_data,
   output logic                                     stbuf_full,
   output logic                                     stbuf_empty
);

   logic [STBUF_DEPTH-1:0]    ent_drain;
   stbuf_addr_u               ent_addr [STBUF_DEPTH];
   logic [STBUF_PTR_BITS:0]   num_vld;

   // ----------------------------------------
   // control bits
   // ----------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         ent_valid <= '0;
         ent_drain <= '0;
         ent_flush <= '0;
      end else begin
         for (int i = 0; i < STBUF_DEPTH; i++) begin
            if (head.pop && head.rd_idx == STBUF_PTR_BITS'(i)) begin
               ent_valid[i] <= 1'b0;
               ent_drain[i] <= 1'b0;
               ent_flush[i] <= 1'b0;
            end
            if (wr.wr_en && wr.wr_idx == STBUF_PTR_BITS'(i)) begin
               ent_valid[i] <= 1'b1;
            end
            // dc5 resolution, exactly one of the two gets set
            if (res_valid && res_idx == STBUF_PTR_BITS'(i)) begin
               ent_drain[i] <= res_commit;
               ent_flush[i] <= ~res_commit;
            end
         end
      end
   end

   // payload
   always_ff @(posedge clk) begin
      if (wr.wr_en) begin
         ent_addr[wr.wr_idx]   <= wr.wr_addr;
         ent_byteen[wr.wr_idx] <= wr.wr_byteen;
         ent_data[wr.wr_idx]   <= wr.wr_data;
      end
   end

   always_comb begin
      for (int i = 0; i < STBUF_DEPTH; i++) begin
         ent_word[i] = ent_addr[i].f.word;   // forwarding compares words only
      end
   end

   // ----------------------------------------
   // head entry
   // ----------------------------------------
   assign head.head_valid  = ent_valid[head.rd_idx];
   assign head.head_drain  = ent_drain[head.rd_idx];
   assign head.head_flush  = ent_flush[head.rd_idx];
   assign head.head_addr   = ent_addr[head.rd_idx];
   assign head.head_byteen = ent_byteen[head.rd_idx];
   assign head.head_data   = ent_data[head.rd_idx];

   // occupancy
   always_comb begin
      num_vld = '0;
      for (int i = 0; i < STBUF_DEPTH; i++) begin
         num_vld = num_vld + {{STBUF_PTR_BITS{1'b0}}, ent_valid[i]};
      end
   end

   assign stbuf_full  = (num_vld == (STBUF_PTR_BITS+1)'(STBUF_DEPTH));
   assign stbuf_empty = (num_vld == '0);

endmodule

`default_nettype wire

// ==== source/stbuf_alloc.sv ====
// ----------------------------------------
// store buffer allocator
// dc3 byte enables and write pointer,
// index pipe to dc5 for commit or kill
// ----------------------------------------
`default_nettype none

module stbuf_alloc
   import lsu_stbuf_pkg::*;
(
   input  logic                      clk,
   input  logic                      rst,

   input  logic                      store_valid,   // dc3
   input  logic [ADDR_BITS-1:0]      store_addr,
   input  access_size_t              store_size,
   input  logic [DATA_WIDTH-1:0]     store_data,
   input  logic                      store_kill,    // dc5

   stbuf_write_if.alloc              wr,

   output logic                      res_valid,
   output logic [STBUF_PTR_BITS-1:0] res_idx,
   output logic                      res_commit
);

   stbuf_addr_u               st_addr;
   logic [BYTE_WIDTH-1:0]     size_mask;
   logic [BYTE_WIDTH-1:0]     st_byteen;
   logic [STBUF_PTR_BITS-1:0] wr_ptr;
   logic                      vld_dc4, vld_dc5;
   logic [STBUF_PTR_BITS-1:0] idx_dc4, idx_dc5;

   assign st_addr = store_addr;

   // ----------------------------------------
   // byte enables
   // ----------------------------------------
   always_comb begin
      case (store_size)
         size_byte: size_mask = 4'b0001;
         size_half: size_mask = 4'b0011;
         size_word: size_mask = 4'b1111;
         default:   size_mask = 4'b0000;
      endcase
   end

   // aligned only, bytes shifted past byte 3 drop off
   assign st_byteen = size_mask << st_addr.f.offset;

   assign wr.wr_en     = store_valid;
   assign wr.wr_idx    = wr_ptr;
   assign wr.wr_addr   = st_addr;
   assign wr.wr_byteen = st_byteen;
   assign wr.wr_data   = store_data;

   // ----------------------------------------
   // write pointer and dc4/dc5 pipe
   // ----------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr  <= '0;
         vld_dc4 <= 1'b0;
         vld_dc5 <= 1'b0;
      end else begin
         if (store_valid) begin
            wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
         end
         vld_dc4 <= store_valid;
         vld_dc5 <= vld_dc4;
      end
   end

   always_ff @(posedge clk) begin
      idx_dc4 <= wr_ptr;
      idx_dc5 <= idx_dc4;
   end

   // resolution lands two cycles after the write
   assign res_valid  = vld_dc5;
   assign res_idx    = idx_dc5;
   assign res_commit = ~store_kill;

endmodule

`default_nettype wire

// ==== source/stbuf_head_if.sv ====
// ----------------------------------------
// store buffer head port
// head entry out of the array, read
// pointer and pop back from the drain
// ----------------------------------------
`default_nettype none

interface stbuf_head_if
   import lsu_stbuf_pkg::*;
();

   // array side
   logic                      head_valid;
   logic                      head_drain;   // committed
   logic                      head_flush;   // killed
   stbuf_addr_u               head_addr;
   logic [BYTE_WIDTH-1:0]     head_byteen;
   logic [DATA_WIDTH-1:0]     head_data;

   // drain side
   logic [STBUF_PTR_BITS-1:0] rd_idx;
   logic                      pop;          // one cycle, clears entry at rd_idx

   modport array (
      output head_valid, head_drain, head_flush, head_addr, head_byteen, head_data,
      input  rd_idx, pop
   );

   modport drain (
      input  head_valid, head_drain, head_flush, head_addr, head_byteen, head_data,
      output rd_idx, pop
   );

endinterface

`default_nettype wire

// ==== source/stbuf_write_if.sv ====
// ----------------------------------------
// store buffer entry write
// one entry per cycle, allocator to array
// ----------------------------------------
`default_nettype none

interface stbuf_write_if
   import lsu_stbuf_pkg::*;
();

   logic                      wr_en;      // write on this edge
   logic [STBUF_PTR_BITS-1:0] wr_idx;     // also the current write pointer
   stbuf_addr_u               wr_addr;
   logic [BYTE_WIDTH-1:0]     wr_byteen;
   logic [DATA_WIDTH-1:0]     wr_data;

   modport alloc (output wr_en, wr_idx, wr_addr, wr_byteen, wr_data);
   modport array (input  wr_en, wr_idx, wr_addr, wr_byteen, wr_data);

endinterface

`default_nettype wire

// ==== source/lsu_stbuf_pkg.sv ====
// ----------------------------------------
// lsu store buffer package
// sizes, access size encoding, drain FSM
// codes and the store address union
// ----------------------------------------
`default_nettype none

package lsu_stbuf_pkg;

   localparam int STBUF_DEPTH    = 4;
   localparam int STBUF_PTR_BITS = 2;   // log2 of depth
   localparam int DATA_WIDTH     = 32;
   localparam int BYTE_WIDTH     = 4;
   localparam int ADDR_BITS      = 16;
   localparam int WORD_BITS      = ADDR_BITS - 2;

   // drain FSM codes
   localparam logic [1:0] DRAIN_IDLE    = 2'd0;
   localparam logic [1:0] DRAIN_REQ     = 2'd1;
   localparam logic [1:0] DRAIN_ACK_LOW = 2'd2;   // wait for ack to return low

   typedef enum logic [1:0] {
      size_byte = 2'd0,
      size_half = 2'd1,
      size_word = 2'd2
   } access_size_t;

   // one store address, seen flat or as word index plus byte offset
   typedef union packed {
      logic [ADDR_BITS-1:0] flat;
      struct packed {
         logic [WORD_BITS-1:0] word;
         logic [1:0]           offset;
      } f;
   } stbuf_addr_u;

endpackage

`default_nettype wire
